//--- Bender.yml
package:
  name: dual_port_ram

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/ram_types_pkg.sv
      - design/access_pkg.sv
      - design/stage_delay.sv
      - design/req_stage.sv
      - design/bram_dual.sv
      - design/read_return.sv
      - design/dual_port_ram_top.sv
  - target: test
    files:
      - testbench/ram_checker.sv
      - testbench/tb_dual_port_ram.sv

//--- design/access_pkg.sv
// Host access codes and the read latency seen at the host ports.
// Code 2'b11 is not defined and acts as idle.

`include "ram_cfg.svh"

package access_pkg;

    // Per-cycle host access code.
    typedef enum logic [1:0] {
        ACC_IDLE  = 2'b00,
        ACC_READ  = 2'b01,
        ACC_WRITE = 2'b10
    } access_e;

    // Sampled read to rvalid: request register, RAM read, optional output register.
    localparam int READ_LATENCY = 2 + `RAM_OUT_REG;

endpackage

//--- design/bram_dual.sv
// True dual-port block RAM, read-first on each port, with byte-masked writes.
// Both ports writing one byte in the same cycle is undefined. Contents start at zero.

`timescale 1ns/1ns

`include "ram_cfg.svh"

module bram_dual
    import ram_types_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,

    input  logic  ram_en0,
    input  mask_t ram_we0,
    input  addr_t ram_addr0,
    input  word_t ram_wdata0,
    input  logic  out_en0,
    output word_t ram_rdata0,

    input  logic  ram_en1,
    input  mask_t ram_we1,
    input  addr_t ram_addr1,
    input  word_t ram_wdata1,
    input  logic  out_en1,
    output word_t ram_rdata1
);

    word_t mem [RAM_WORDS];

    // Port signals gathered so both ports share one generate body.
    logic  en_p    [2];
    mask_t we_p    [2];
    addr_t addr_p  [2];
    word_t wdata_p [2];
    logic  oen_p   [2];
    word_t rd_raw  [2];
    word_t rd_out  [2];

    assign en_p    = '{ram_en0, ram_en1};
    assign we_p    = '{ram_we0, ram_we1};
    assign addr_p  = '{ram_addr0, ram_addr1};
    assign wdata_p = '{ram_wdata0, ram_wdata1};
    assign oen_p   = '{out_en0, out_en1};

    initial begin
        for (int i = 0; i < RAM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // **************************************************
    // Array access, one process per port and byte lane
    // **************************************************

    // Separate processes keep the two ports free of write priority,
    // which is what lets synthesis map this onto a true dual-port RAM.
    for (genvar p = 0; p < 2; p++) begin : g_port
        for (genvar k = 0; k < RAM_BYTES; k++) begin : g_lane
            always @(posedge clk) begin
                if (en_p[p]) begin
                    if (we_p[p][k]) begin
                        mem[addr_p[p]][k*8 +: 8] <= wdata_p[p][k*8 +: 8];
                    end
                    // Old contents, so a read-and-write sees the previous byte.
                    rd_raw[p][k*8 +: 8] <= mem[addr_p[p]][k*8 +: 8];
                end
            end
        end

        if (`RAM_OUT_REG) begin : g_oreg
            stage_delay #(
                .T     (word_t),
                .DEPTH (1)
            ) u_oreg (
                .clk    (clk),
                .arst_n (arst_n),
                .en     (oen_p[p]),
                .d      (rd_raw[p]),
                .q      (rd_out[p])
            );
        end else begin : g_no_oreg
            assign rd_out[p] = rd_raw[p];
        end
    end

    assign ram_rdata0 = rd_out[0];
    assign ram_rdata1 = rd_out[1];

endmodule

//--- design/dual_port_ram_top.sv
// Two-port scratch memory with byte write masks and no arbitration.
// Same-byte writes from both ports in one cycle are illegal. Reads return after READ_LATENCY.

`timescale 1ns/1ns

module dual_port_ram_top
    import ram_types_pkg::*;
    import access_pkg::*;
(
    input  logic    clk,
    input  logic    arst_n,

    input  access_e acc0,
    input  addr_t   addr0,
    input  word_t   wdata0,
    input  mask_t   wmask0,
    output logic    rvalid0,
    output addr_t   raddr0,
    output word_t   rdata0,

    input  access_e acc1,
    input  addr_t   addr1,
    input  word_t   wdata1,
    input  mask_t   wmask1,
    output logic    rvalid1,
    output addr_t   raddr1,
    output word_t   rdata1
);

    logic  ram_en0, ram_en1;
    mask_t ram_we0, ram_we1;
    addr_t ram_addr0, ram_addr1;
    word_t ram_wdata0, ram_wdata1;
    word_t ram_rdata0, ram_rdata1;
    logic  rd_issue0, rd_issue1;
    logic  out_en0, out_en1;

    // **************************************************
    // Port 0 and port 1 request stages
    // **************************************************

    req_stage u_req0 (
        .clk, .arst_n,
        .acc (acc0), .addr (addr0), .wdata (wdata0), .wmask (wmask0),
        .ram_en (ram_en0), .ram_we (ram_we0), .ram_addr (ram_addr0),
        .ram_wdata (ram_wdata0), .rd_issue (rd_issue0)
    );

    req_stage u_req1 (
        .clk, .arst_n,
        .acc (acc1), .addr (addr1), .wdata (wdata1), .wmask (wmask1),
        .ram_en (ram_en1), .ram_we (ram_we1), .ram_addr (ram_addr1),
        .ram_wdata (ram_wdata1), .rd_issue (rd_issue1)
    );

    bram_dual u_ram (
        .clk, .arst_n,
        .ram_en0, .ram_we0, .ram_addr0, .ram_wdata0, .out_en0, .ram_rdata0,
        .ram_en1, .ram_we1, .ram_addr1, .ram_wdata1, .out_en1, .ram_rdata1
    );

    // **************************************************
    // Read returns
    // **************************************************

    read_return u_ret0 (
        .clk, .arst_n,
        .rd_issue (rd_issue0), .ram_addr (ram_addr0), .ram_rdata (ram_rdata0),
        .out_en (out_en0), .rvalid (rvalid0), .raddr (raddr0), .rdata (rdata0)
    );

    read_return u_ret1 (
        .clk, .arst_n,
        .rd_issue (rd_issue1), .ram_addr (ram_addr1), .ram_rdata (ram_rdata1),
        .out_en (out_en1), .rvalid (rvalid1), .raddr (raddr1), .rdata (rdata1)
    );

endmodule

//--- design/ram_cfg.svh
// Build-time configuration of the scratch RAM.
// RAM_DATA_WIDTH must be a multiple of 8. RAM_OUT_REG adds one cycle of read latency.

`ifndef RAM_CFG_SVH
`define RAM_CFG_SVH

// **************************************************
// Storage geometry
// **************************************************

// Word width in bits.
`define RAM_DATA_WIDTH 32

// Word address width, 256 words.
`define RAM_ADDR_WIDTH 8

// **************************************************
// Read path
// **************************************************

// 1 puts a register on each RAM read port, 0 leaves it out.
`define RAM_OUT_REG 1

`endif

//--- design/ram_types_pkg.sv
// Storage types of the scratch RAM, sized from the build configuration.
// The byte mask holds one bit per 8-bit lane of the word.

`include "ram_cfg.svh"

package ram_types_pkg;

    // Byte lanes per word.
    localparam int RAM_BYTES = `RAM_DATA_WIDTH / 8;

    // Number of words in the array.
    localparam int RAM_WORDS = 2 ** `RAM_ADDR_WIDTH;

    // One data word.
    typedef logic [`RAM_DATA_WIDTH-1:0] word_t;

    // One word address.
    typedef logic [`RAM_ADDR_WIDTH-1:0] addr_t;

    // Byte write mask, bit k covers bits 8k+7 down to 8k.
    typedef logic [RAM_BYTES-1:0] mask_t;

endpackage

//--- design/read_return.sv
// Read return path of one host port.
// Every rd_issue yields one rvalid READ_LATENCY-1 cycles later. The host cannot stall it.

`timescale 1ns/1ns

module read_return
    import ram_types_pkg::*;
    import access_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,

    input  logic  rd_issue,
    input  addr_t ram_addr,
    input  word_t ram_rdata,

    output logic  out_en,
    output logic  rvalid,
    output addr_t raddr,
    output word_t rdata
);

    logic issue_q;

    // Set in the cycle the raw RAM read word is present.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            issue_q <= 1'b0;
        end else begin
            issue_q <= rd_issue;
        end
    end

    // Output register loads only for answers, so it keeps the last read word.
    assign out_en = issue_q;

    // **************************************************
    // Valid flag and address tag, matched to RAM latency
    // **************************************************

    stage_delay #(
        .T     (logic),
        .DEPTH (READ_LATENCY - 1)
    ) u_valid_dly (
        .clk    (clk),
        .arst_n (arst_n),
        .en     (1'b1),
        .d      (rd_issue),
        .q      (rvalid)
    );

    stage_delay #(
        .T     (addr_t),
        .DEPTH (READ_LATENCY - 1)
    ) u_addr_dly (
        .clk    (clk),
        .arst_n (arst_n),
        .en     (1'b1),
        .d      (ram_addr),
        .q      (raddr)
    );

    // Data is shown only with its valid pulse.
    assign rdata = rvalid ? ram_rdata : '0;

endmodule

//--- design/req_stage.sv
// Input register of one host port.
// Requests are sampled every cycle with no handshake. Undefined codes act as idle.

`timescale 1ns/1ns

module req_stage
    import ram_types_pkg::*;
    import access_pkg::*;
(
    input  logic    clk,
    input  logic    arst_n,

    input  access_e acc,
    input  addr_t   addr,
    input  word_t   wdata,
    input  mask_t   wmask,

    output logic    ram_en,
    output mask_t   ram_we,
    output addr_t   ram_addr,
    output word_t   ram_wdata,
    output logic    rd_issue
);

    logic is_read;
    logic is_write;

    assign is_read  = (acc == ACC_READ);
    assign is_write = (acc == ACC_WRITE);

    // **************************************************
    // Control, cleared to idle on reset
    // **************************************************

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ram_en   <= 1'b0;
            ram_we   <= '0;
            rd_issue <= 1'b0;
        end else begin
            // A write with an empty mask leaves the RAM untouched.
            ram_en   <= is_read || (is_write && (wmask != '0));
            ram_we   <= is_write ? wmask : '0;
            rd_issue <= is_read;
        end
    end

    // Address and write data travel alongside the control.
    always_ff @(posedge clk) begin
        ram_addr  <= addr;
        ram_wdata <= wdata;
    end

endmodule

//--- design/stage_delay.sv
// Register chain of DEPTH stages for any packed payload type.
// DEPTH must be at least 1. All stages hold while en is low.

`timescale 1ns/1ns

module stage_delay #(
    parameter type T     = logic,
    parameter int  DEPTH = 1
)(
    input  logic clk,
    input  logic arst_n,
    input  logic en,
    input  T     d,
    output T     q
);

    T stages [DEPTH];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                stages[i] <= '0;
            end
        end else if (en) begin
            stages[0] <= d;
            // Shift toward the output end.
            for (int i = 1; i < DEPTH; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

    // Last stage is the output.
    assign q = stages[DEPTH-1];

endmodule

//--- list.f
+incdir+design
design/ram_types_pkg.sv
design/access_pkg.sv
design/stage_delay.sv
design/req_stage.sv
design/bram_dual.sv
design/read_return.sv
design/dual_port_ram_top.sv
testbench/ram_checker.sv
testbench/tb_dual_port_ram.sv

//--- testbench/ram_checker.sv
// Concurrent checks on the scratch RAM top level, bound into every instance.
// Same-byte writes from both ports in one cycle are illegal and flagged here.

`timescale 1ns/1ns

module ram_checker
    import ram_types_pkg::*;
    import access_pkg::*;
(
    input logic    clk,
    input logic    arst_n,
    input access_e acc0,
    input addr_t   addr0,
    input mask_t   wmask0,
    input logic    rvalid0,
    input access_e acc1,
    input addr_t   addr1,
    input mask_t   wmask1,
    input logic    rvalid1
);

    // Count of failed assertions, read by the testbench at the end.
    int failures = 0;

    // Return paths stay quiet while reset is held.
    a_reset_quiet: assert property (@(posedge clk) !arst_n |-> (!rvalid0 && !rvalid1))
        else begin
            $error("rvalid high during reset");
            failures++;
        end

    // **************************************************
    // Read latency and write silence per port
    // **************************************************

    a_read_ret0: assert property (@(posedge clk) disable iff (!arst_n)
        (acc0 == ACC_READ) |-> ##READ_LATENCY rvalid0)
        else begin
            $error("port 0 read without rvalid at READ_LATENCY");
            failures++;
        end

    a_read_ret1: assert property (@(posedge clk) disable iff (!arst_n)
        (acc1 == ACC_READ) |-> ##READ_LATENCY rvalid1)
        else begin
            $error("port 1 read without rvalid at READ_LATENCY");
            failures++;
        end

    a_write_quiet0: assert property (@(posedge clk) disable iff (!arst_n)
        (acc0 == ACC_WRITE) |-> ##READ_LATENCY !rvalid0)
        else begin
            $error("port 0 write produced rvalid");
            failures++;
        end

    a_write_quiet1: assert property (@(posedge clk) disable iff (!arst_n)
        (acc1 == ACC_WRITE) |-> ##READ_LATENCY !rvalid1)
        else begin
            $error("port 1 write produced rvalid");
            failures++;
        end

    // Both ports writing the same byte in one cycle.
    a_no_collide: assert property (@(posedge clk) disable iff (!arst_n)
        (acc0 == ACC_WRITE && acc1 == ACC_WRITE && addr0 == addr1) |-> ((wmask0 & wmask1) == '0))
        else begin
            $error("overlapping same-address writes on both ports");
            failures++;
        end

endmodule

bind dual_port_ram_top ram_checker u_checker (
    .clk (clk), .arst_n (arst_n),
    .acc0 (acc0), .addr0 (addr0), .wmask0 (wmask0), .rvalid0 (rvalid0),
    .acc1 (acc1), .addr1 (addr1), .wmask1 (wmask1), .rvalid1 (rvalid1)
);

//--- testbench/tb_dual_port_ram.sv
// Self-checking testbench for the two-port scratch RAM.
// The shadow model does not depend on READ_LATENCY; answers are matched in issue order.

`timescale 1ns/1ns

module tb_dual_port_ram
    import ram_types_pkg::*;
    import access_pkg::*;
();

    localparam int CLK_PERIOD      = 40;
    localparam int DRIVE_DELAY     = 5;
    localparam int RESET_CYCLES    = 16;
    localparam int DIRECTED_CYCLES = 300;
    localparam int RANDOM_CYCLES   = 2000;
    localparam int MARGIN_CYCLES   = 200;
    localparam int DRAIN_LIMIT     = 4 * READ_LATENCY;

    logic    clk;
    logic    arst_n;
    access_e acc0, acc1;
    addr_t   addr0, addr1;
    word_t   wdata0, wdata1;
    mask_t   wmask0, wmask1;
    logic    rvalid0, rvalid1;
    addr_t   raddr0, raddr1;
    word_t   rdata0, rdata1;

    // Shadow copy of the array and the answers still owed per port.
    word_t shadow [RAM_WORDS];
    addr_t exp_addr0 [$];
    word_t exp_data0 [$];
    addr_t exp_addr1 [$];
    word_t exp_data1 [$];

    // Access for the next cycle, staged per port.
    access_e nxt_acc   [2];
    addr_t   nxt_addr  [2];
    word_t   nxt_wdata [2];
    mask_t   nxt_mask  [2];

    int checks;
    int errors;
    int tests;
    int test_err_base;
    int assert_fails;

    dual_port_ram_top UUT (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // **************************************************
    // Reference model
    // **************************************************

    function automatic word_t expected_word(input addr_t a);
        return shadow[a];
    endfunction

    function automatic word_t merge_bytes(input word_t old, input word_t wd, input mask_t m);
        word_t res;
        res = old;
        for (int k = 0; k < RAM_BYTES; k++) begin
            if (m[k]) begin
                res[k*8 +: 8] = wd[k*8 +: 8];
            end
        end
        return res;
    endfunction

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic stage_access(input int p, input access_e a, input addr_t ad,
                                input word_t wd, input mask_t m);
        nxt_acc[p]   = a;
        nxt_addr[p]  = ad;
        nxt_wdata[p] = wd;
        nxt_mask[p]  = m;
    endtask

    // Drives one cycle of staged accesses and updates the model.
    task automatic run_cycle();
        word_t old0;
        word_t old1;
        @(posedge clk);
        #DRIVE_DELAY;
        acc0   = nxt_acc[0];
        addr0  = nxt_addr[0];
        wdata0 = nxt_wdata[0];
        wmask0 = nxt_mask[0];
        acc1   = nxt_acc[1];
        addr1  = nxt_addr[1];
        wdata1 = nxt_wdata[1];
        wmask1 = nxt_mask[1];
        // Reads see the contents from before this cycle's writes.
        old0 = expected_word(nxt_addr[0]);
        old1 = expected_word(nxt_addr[1]);
        if (nxt_acc[0] == ACC_READ) begin
            exp_addr0.push_back(nxt_addr[0]);
            exp_data0.push_back(old0);
        end
        if (nxt_acc[1] == ACC_READ) begin
            exp_addr1.push_back(nxt_addr[1]);
            exp_data1.push_back(old1);
        end
        for (int p = 0; p < 2; p++) begin
            if (nxt_acc[p] == ACC_WRITE) begin
                shadow[nxt_addr[p]] = merge_bytes(shadow[nxt_addr[p]], nxt_wdata[p], nxt_mask[p]);
            end
            stage_access(p, ACC_IDLE, '0, '0, '0);
        end
    endtask

    task automatic take_answer(input int p, input addr_t ra, input word_t rd);
        addr_t ea;
        word_t ed;
        if ((p == 0 && exp_addr0.size() == 0) || (p == 1 && exp_addr1.size() == 0)) begin
            errors++;
            $display("error at %0t ns: port %0d gave rvalid with no read outstanding", $time, p);
        end else begin
            if (p == 0) begin
                ea = exp_addr0.pop_front();
                ed = exp_data0.pop_front();
            end else begin
                ea = exp_addr1.pop_front();
                ed = exp_data1.pop_front();
            end
            check_value($sformatf("port %0d raddr", p), ra, ea);
            check_value($sformatf("port %0d rdata", p), rd, ed);
        end
    endtask

    // Outputs are sampled mid-cycle, clear of the rising edge.
    always @(negedge clk) begin
        if (arst_n) begin
            if (rvalid0) begin
                take_answer(0, raddr0, rdata0);
            end
            if (rvalid1) begin
                take_answer(1, raddr1, rdata1);
            end
        end
    end

    // Idles the ports, waits for owed answers and prints the test line.
    task automatic close_test(input string name);
        int waited;
        waited = 0;
        run_cycle();
        while ((exp_addr0.size() + exp_addr1.size()) != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if ((exp_addr0.size() + exp_addr1.size()) != 0) begin
            errors++;
            $display("error at %0t ns: %0d reads on port 0 and %0d on port 1 never returned",
                     $time, exp_addr0.size(), exp_addr1.size());
            exp_addr0.delete();
            exp_data0.delete();
            exp_addr1.delete();
            exp_data1.delete();
        end
        tests++;
        $display("test %0d %s: %0d errors", tests, name, errors - test_err_base);
        test_err_base = errors;
    endtask

    // **************************************************
    // Stimulus
    // **************************************************

    initial begin
        void'($urandom(32'ha241_b48b));
        arst_n = 1'b1;
        clk    = 1'b0;
        acc0   = ACC_IDLE;
        addr0  = '0;
        wdata0 = '0;
        wmask0 = '0;
        acc1   = ACC_IDLE;
        addr1  = '0;
        wdata1 = '0;
        wmask1 = '0;
        checks = 0;
        errors = 0;
        tests  = 0;
        test_err_base = 0;
        for (int i = 0; i < RAM_WORDS; i++) begin
            shadow[i] = '0;
        end
        for (int p = 0; p < 2; p++) begin
            stage_access(p, ACC_IDLE, '0, '0, '0);
        end
        #DRIVE_DELAY;
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        arst_n = 1'b1;

        check_value("rvalid0 after reset", rvalid0, 1'b0);
        check_value("rvalid1 after reset", rvalid1, 1'b0);
        for (int i = 0; i < 8; i++) begin
            stage_access(0, ACC_READ, addr_t'(i), '0, '0);
            stage_access(1, ACC_READ, addr_t'(255 - i), '0, '0);
            run_cycle();
        end
        close_test("reset and untouched reads");

        for (int i = 0; i < 8; i++) begin
            stage_access(0, ACC_WRITE, addr_t'(16 + i), word_t'($urandom), '1);
            stage_access(1, ACC_WRITE, addr_t'(32 + i), word_t'($urandom), '1);
            run_cycle();
        end
        for (int i = 0; i < 8; i++) begin
            stage_access(0, ACC_READ, addr_t'(16 + i), '0, '0);
            stage_access(1, ACC_READ, addr_t'(32 + i), '0, '0);
            run_cycle();
        end
        close_test("full-word write and back-to-back read");

        // Every mask value, zero included, over four words.
        for (int i = 0; i < 16; i++) begin
            stage_access(0, ACC_WRITE, addr_t'(48 + i % 4), word_t'($urandom), mask_t'(i));
            stage_access(1, ACC_WRITE, addr_t'(52 + i % 4), word_t'($urandom), mask_t'(15 - i));
            run_cycle();
        end
        for (int i = 0; i < 4; i++) begin
            stage_access(0, ACC_READ, addr_t'(48 + i), '0, '0);
            stage_access(1, ACC_READ, addr_t'(52 + i), '0, '0);
            run_cycle();
        end
        close_test("byte-masked merge");

        for (int i = 0; i < 8; i++) begin
            stage_access(0, ACC_WRITE, addr_t'(64 + i), word_t'($urandom), '1);
            stage_access(1, ACC_WRITE, addr_t'(80 + i), word_t'($urandom), '1);
            run_cycle();
        end
        for (int i = 0; i < 8; i++) begin
            stage_access(0, ACC_READ, addr_t'(80 + i), '0, '0);
            stage_access(1, ACC_READ, addr_t'(64 + i), '0, '0);
            run_cycle();
        end
        close_test("cross-port readback");

        stage_access(0, ACC_WRITE, 8'd100, 32'h1111_1111, '1);
        stage_access(1, ACC_WRITE, 8'd101, 32'h2222_2222, '1);
        run_cycle();
        stage_access(0, ACC_READ, 8'd100, '0, '0);
        stage_access(1, ACC_WRITE, 8'd100, 32'haaaa_aaaa, '1);
        run_cycle();
        stage_access(1, ACC_READ, 8'd101, '0, '0);
        stage_access(0, ACC_WRITE, 8'd101, 32'h5555_5555, '1);
        run_cycle();
        stage_access(0, ACC_READ, 8'd101, '0, '0);
        stage_access(1, ACC_READ, 8'd100, '0, '0);
        run_cycle();
        close_test("read-first across ports");

        // Narrow address range so the ports often meet.
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            stage_access(0, access_e'($urandom_range(2)), addr_t'($urandom_range(15)),
                         word_t'($urandom), mask_t'($urandom_range(15)));
            stage_access(1, access_e'($urandom_range(2)), addr_t'($urandom_range(15)),
                         word_t'($urandom), mask_t'($urandom_range(15)));
            if (nxt_acc[0] == ACC_WRITE && nxt_acc[1] == ACC_WRITE
                && nxt_addr[0] == nxt_addr[1]) begin
                nxt_mask[1] = nxt_mask[1] & ~nxt_mask[0];
            end
            run_cycle();
        end
        close_test("random mixed traffic");

        assert_fails = UUT.u_checker.failures;
        $display("tests: %0d, checks: %0d, errors: %0d, assertion failures: %0d",
                 tests, checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog sized from the reset, directed and random cycle counts.
    initial begin
        #((RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("timeout: the tests did not finish within the expected run time");
        $display("RESULT: FAIL");
        $finish;
    end

endmodule
